//--- hw/core_cfg_pkg.sv
// Core configuration
// Widths and counts that shape the shared instruction types
`default_nettype none

package core_cfg_pkg;

    // Datapath width
    localparam int XLEN = 32;

    // Instruction ID space, one commit buffer slot per ID
    localparam int ID_W    = 3;
    localparam int NUM_IDS = 2 ** ID_W;

    // Eight architectural registers, r0 hardwired to zero
    localparam int REG_ADDR_W = 3;

    // Sign-extended immediate
    localparam int IMM_W = 16;

endpackage

`default_nettype wire

//--- hw/instr_types_pkg.sv
// Instruction types
// Opcodes and the packed records passed between pipeline blocks
`default_nettype none

package instr_types_pkg;
    import core_cfg_pkg::*;

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_ADDI,
        OP_MUL
    } op_t;

    // Instruction as it arrives on the input port
    typedef struct packed {
        op_t                   op;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [IMM_W-1:0]      imm;
    } instr_t;

    // Operands resolved at issue, b already holds the immediate for ADDI
    typedef struct packed {
        op_t             op;
        logic [ID_W-1:0] id;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
    } dispatch_t;

    // Tagged result from an execution unit
    typedef struct packed {
        logic            done;
        logic [ID_W-1:0] id;
        logic [XLEN-1:0] result;
    } unit_wb_t;

    // Retired instruction, also the register file write
    typedef struct packed {
        logic [ID_W-1:0]       id;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } retire_t;

endpackage

`default_nettype wire

//--- hw/id_tracker.sv
// Instruction ID tracker
// Hands out IDs in rotating order and frees them in the same order
`default_nettype none

module id_tracker import core_cfg_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            issued,
    input  logic            retired,
    output logic            id_available,
    output logic [ID_W-1:0] next_id,
    output logic [ID_W-1:0] oldest_id,
    output logic            empty
);

    // Extra bit tells a full pool from an empty one
    logic [ID_W:0] inflight;

    always_ff @(posedge clk) begin
        if (rst) begin
            next_id   <= '0;
            oldest_id <= '0;
            inflight  <= '0;
        end else begin
            // Head and tail wrap at NUM_IDS on their own
            if (issued)
                next_id <= next_id + ID_W'(1);
            if (retired)
                oldest_id <= oldest_id + ID_W'(1);
            inflight <= inflight + (ID_W+1)'(issued) - (ID_W+1)'(retired);
        end
    end

    // Slot reuse only after the previous owner of the ID has retired
    assign id_available = (inflight != (ID_W+1)'(NUM_IDS));
    assign empty        = (inflight == '0);

endmodule

`default_nettype wire

//--- hw/issue_stage.sv
// Issue stage
// Credit-fed instruction queue, operand hazard check with bypass,
// ID allocation and dispatch to the ALU or the multiplier
`default_nettype none

module issue_stage import core_cfg_pkg::*; import instr_types_pkg::*; #(
    parameter int IQ_DEPTH = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    input  instr_t                in_instr,
    output logic                  in_credit,
    input  logic                  id_available,
    input  logic [ID_W-1:0]       next_id,
    output logic                  issued,
    output logic [REG_ADDR_W-1:0] rs1_addr,
    output logic [REG_ADDR_W-1:0] rs2_addr,
    input  logic [XLEN-1:0]       rs1_reg,
    input  logic [XLEN-1:0]       rs2_reg,
    input  logic                  rs1_pending,
    input  logic                  rs2_pending,
    input  logic [ID_W-1:0]       rs1_writer,
    input  logic [ID_W-1:0]       rs2_writer,
    input  logic                  rs1_byp_valid,
    input  logic                  rs2_byp_valid,
    input  logic [XLEN-1:0]       rs1_byp_data,
    input  logic [XLEN-1:0]       rs2_byp_data,
    output dispatch_t             alu_disp,
    output dispatch_t             mul_disp,
    output logic                  alu_valid,
    output logic                  mul_valid,
    output logic [REG_ADDR_W-1:0] claim_rd
);

    localparam int PTR_W = $clog2(IQ_DEPTH);
    localparam int CNT_W = $clog2(IQ_DEPTH + 1);

    instr_t           queue [IQ_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    instr_t           head;
    logic             uses_rs2;
    logic             rs1_ready;
    logic             rs2_ready;
    logic             fire;
    logic [XLEN-1:0]  op_a;
    logic [XLEN-1:0]  op_b;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(IQ_DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
    endfunction

    ////////////////////////////////////////////////////////////
    // Instruction queue
    // Sender holds a credit per free entry, so no full check
    always_ff @(posedge clk) begin
        if (in_valid)
            queue[wr_ptr] <= in_instr;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (in_valid)
                wr_ptr <= ptr_inc(wr_ptr);
            if (fire)
                rd_ptr <= ptr_inc(rd_ptr);
            count <= count + CNT_W'(in_valid) - CNT_W'(fire);
        end
    end

    ////////////////////////////////////////////////////////////
    // Operand hazard check on the queue head
    assign head     = queue[rd_ptr];
    assign rs1_addr = head.rs1;
    assign rs2_addr = head.rs2;
    assign uses_rs2 = (head.op != OP_ADDI);

    // A pending source is usable once its writer sits in the commit buffer
    assign rs1_ready = !rs1_pending || rs1_byp_valid;
    assign rs2_ready = !uses_rs2 || !rs2_pending || rs2_byp_valid;
    assign fire      = (count != '0) && id_available && rs1_ready && rs2_ready;

    // Operand select: register file value or buffered result
    assign op_a = rs1_pending ? rs1_byp_data : rs1_reg;

    always_comb begin
        if (!uses_rs2)
            op_b = {{(XLEN-IMM_W){head.imm[IMM_W-1]}}, head.imm};
        else if (rs2_pending)
            op_b = rs2_byp_data;
        else
            op_b = rs2_reg;
    end

    ////////////////////////////////////////////////////////////
    // Dispatch and ID allocation
    assign alu_disp  = '{op: head.op, id: next_id, a: op_a, b: op_b};
    assign mul_disp  = alu_disp;
    assign alu_valid = fire && (head.op != OP_MUL);
    assign mul_valid = fire && (head.op == OP_MUL);

    // Same pulse frees a queue entry and claims the ID
    assign issued    = fire;
    assign in_credit = fire;
    assign claim_rd  = head.rd;

endmodule

`default_nettype wire

//--- hw/alu_unit.sv
// Integer ALU
// Single-cycle add, subtract, logic ops and signed compare
`default_nettype none

module alu_unit import core_cfg_pkg::*; import instr_types_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  dispatch_t disp,
    input  logic      valid,
    output unit_wb_t  wb
);

    logic [XLEN-1:0] result;

    always_comb begin
        case (disp.op)
            // ADDI arrives with the immediate already in b
            OP_ADD, OP_ADDI: result = disp.a + disp.b;
            OP_SUB:          result = disp.a - disp.b;
            OP_AND:          result = disp.a & disp.b;
            OP_OR:           result = disp.a | disp.b;
            OP_XOR:          result = disp.a ^ disp.b;
            // Signed compare, 0 or 1
            OP_SLT:          result = XLEN'($signed(disp.a) < $signed(disp.b));
            default:         result = '0;
        endcase
    end

    // Result tagged with its ID, one cycle after dispatch
    always_ff @(posedge clk) begin
        wb.id     <= disp.id;
        wb.result <= result;
        if (rst)
            wb.done <= 1'b0;
        else
            wb.done <= valid;
    end

endmodule

`default_nettype wire

//--- hw/mul_unit.sv
// Pipelined multiplier
// Low XLEN bits of the product, MUL_LATENCY cycles after dispatch,
// one new operation accepted per cycle
`default_nettype none

module mul_unit import core_cfg_pkg::*; import instr_types_pkg::*; #(
    parameter int MUL_LATENCY = 3
) (
    input  logic      clk,
    input  logic      rst,
    input  dispatch_t disp,
    input  logic      valid,
    output unit_wb_t  wb
);

    logic            stage_valid [MUL_LATENCY];
    logic [ID_W-1:0] stage_id    [MUL_LATENCY];
    logic [XLEN-1:0] stage_prod  [MUL_LATENCY];
    logic [XLEN-1:0] product;

    assign product = disp.a * disp.b;

    // Payload shift, each stage holds its own operation
    always_ff @(posedge clk) begin
        stage_id[0]   <= disp.id;
        stage_prod[0] <= product;
        for (int i = 1; i < MUL_LATENCY; i++) begin
            stage_id[i]   <= stage_id[i-1];
            stage_prod[i] <= stage_prod[i-1];
        end
    end

    // Valid bits travel alongside
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < MUL_LATENCY; i++)
                stage_valid[i] <= 1'b0;
        end else begin
            stage_valid[0] <= valid;
            for (int i = 1; i < MUL_LATENCY; i++)
                stage_valid[i] <= stage_valid[i-1];
        end
    end

    assign wb.done   = stage_valid[MUL_LATENCY-1];
    assign wb.id     = stage_id[MUL_LATENCY-1];
    assign wb.result = stage_prod[MUL_LATENCY-1];

endmodule

`default_nettype wire

//--- hw/write_back.sv
// Write-back and commit buffer
// Collects unit results by ID in any order, retires oldest first
// under retire credits and serves operand bypass to issue
`default_nettype none

module write_back import core_cfg_pkg::*; import instr_types_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  unit_wb_t              alu_wb,
    input  unit_wb_t              mul_wb,
    input  logic                  issued,
    input  logic [ID_W-1:0]       issue_id,
    input  logic [REG_ADDR_W-1:0] issue_rd,
    input  logic [ID_W-1:0]       oldest_id,
    output logic                  retired,
    input  logic [ID_W-1:0]       rs1_id,
    input  logic [ID_W-1:0]       rs2_id,
    output logic                  rs1_byp_valid,
    output logic                  rs2_byp_valid,
    output logic [XLEN-1:0]       rs1_byp_data,
    output logic [XLEN-1:0]       rs2_byp_data,
    input  logic                  retire_credit,
    output logic                  retire_valid,
    output retire_t               retire_data
);

    localparam int CREDIT_W = 8;

    logic [XLEN-1:0]       result_buf [NUM_IDS];
    logic [REG_ADDR_W-1:0] rd_meta    [NUM_IDS];
    logic [NUM_IDS-1:0]    pending;
    logic [NUM_IDS-1:0]    done_mask;
    logic [NUM_IDS-1:0]    retire_mask;
    logic [CREDIT_W-1:0]   credits;
    logic                  ready;

    ////////////////////////////////////////////////////////////
    // Commit buffer
    // Units never report the same ID in one cycle
    always_comb begin
        done_mask = '0;
        if (alu_wb.done)
            done_mask[alu_wb.id] = 1'b1;
        if (mul_wb.done)
            done_mask[mul_wb.id] = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (alu_wb.done)
            result_buf[alu_wb.id] <= alu_wb.result;
        if (mul_wb.done)
            result_buf[mul_wb.id] <= mul_wb.result;
    end

    // Destination register per ID, stored at issue
    always_ff @(posedge clk) begin
        if (issued)
            rd_meta[issue_id] <= issue_rd;
    end

    ////////////////////////////////////////////////////////////
    // In-order retirement
    // Oldest ID goes once its result is buffered and a credit is held
    assign ready   = pending[oldest_id] && (credits != '0);
    assign retired = ready;

    always_comb begin
        retire_mask            = '0;
        retire_mask[oldest_id] = ready;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pending      <= '0;
            credits      <= '0;
            retire_valid <= 1'b0;
        end else begin
            pending      <= (pending | done_mask) & ~retire_mask;
            credits      <= credits + CREDIT_W'(retire_credit) - CREDIT_W'(ready);
            retire_valid <= ready;
        end
    end

    always_ff @(posedge clk) begin
        retire_data <= '{id: oldest_id, rd: rd_meta[oldest_id], data: result_buf[oldest_id]};
    end

    ////////////////////////////////////////////////////////////
    // Operand bypass
    // Retiring ID still counts, the register file is written a cycle later
    assign rs1_byp_valid = pending[rs1_id] || (retire_valid && (retire_data.id == rs1_id));
    assign rs2_byp_valid = pending[rs2_id] || (retire_valid && (retire_data.id == rs2_id));
    assign rs1_byp_data  = result_buf[rs1_id];
    assign rs2_byp_data  = result_buf[rs2_id];

endmodule

`default_nettype wire

//--- hw/reg_file.sv
// Architectural register file
// Eight registers with r0 at zero, plus a pending bit and latest
// writer ID per register for issue hazard checks
`default_nettype none

module reg_file import core_cfg_pkg::*; import instr_types_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [REG_ADDR_W-1:0] rs1_addr,
    input  logic [REG_ADDR_W-1:0] rs2_addr,
    output logic [XLEN-1:0]       rs1_reg,
    output logic [XLEN-1:0]       rs2_reg,
    output logic                  rs1_pending,
    output logic                  rs2_pending,
    output logic [ID_W-1:0]       rs1_writer,
    output logic [ID_W-1:0]       rs2_writer,
    input  logic                  issued,
    input  logic [ID_W-1:0]       issue_id,
    input  logic [REG_ADDR_W-1:0] claim_rd,
    input  logic                  retire_valid,
    input  retire_t               retire_data
);

    localparam int NUM_REGS = 2 ** REG_ADDR_W;

    logic [XLEN-1:0]     regs   [NUM_REGS];
    logic [ID_W-1:0]     writer [NUM_REGS];
    logic [NUM_REGS-1:0] pending;
    logic                claim;
    logic                clear;

    // r0 never gets a writer
    assign claim = issued && (claim_rd != '0);

    // Only the latest writer releases the register
    assign clear = retire_valid && (writer[retire_data.rd] == retire_data.id);

    always_ff @(posedge clk) begin
        if (rst)
            regs <= '{default: '0};
        else if (retire_valid && (retire_data.rd != '0))
            regs[retire_data.rd] <= retire_data.data;
    end

    always_ff @(posedge clk) begin
        if (claim)
            writer[claim_rd] <= issue_id;
    end

    // New claim wins over a release in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= '0;
        end else begin
            if (clear)
                pending[retire_data.rd] <= 1'b0;
            if (claim)
                pending[claim_rd] <= 1'b1;
        end
    end

    assign rs1_reg     = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_reg     = (rs2_addr == '0) ? '0 : regs[rs2_addr];
    assign rs1_pending = pending[rs1_addr];
    assign rs2_pending = pending[rs2_addr];
    assign rs1_writer  = writer[rs1_addr];
    assign rs2_writer  = writer[rs2_addr];

endmodule

`default_nettype wire

//--- hw/retire_core_top.sv
// Retire core top level
// In-order issue, out-of-order completion, in-order retirement,
// credit flow control on the instruction and retire ports
`default_nettype none

module retire_core_top import core_cfg_pkg::*; import instr_types_pkg::*; #(
    parameter int MUL_LATENCY = 3,
    parameter int IQ_DEPTH    = 4
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    in_valid,
    input  instr_t  in_instr,
    output logic    in_credit,
    input  logic    retire_credit,
    output logic    retire_valid,
    output retire_t retire_data
);

    // ID allocation
    logic                  id_available;
    logic [ID_W-1:0]       next_id;
    logic [ID_W-1:0]       oldest_id;
    logic                  issued;
    logic                  retired;
    // Register lookup and bypass
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs1_reg;
    logic [XLEN-1:0]       rs2_reg;
    logic                  rs1_pending;
    logic                  rs2_pending;
    logic [ID_W-1:0]       rs1_writer;
    logic [ID_W-1:0]       rs2_writer;
    logic                  rs1_byp_valid;
    logic                  rs2_byp_valid;
    logic [XLEN-1:0]       rs1_byp_data;
    logic [XLEN-1:0]       rs2_byp_data;
    logic [REG_ADDR_W-1:0] claim_rd;
    // Units
    dispatch_t             alu_disp;
    dispatch_t             mul_disp;
    logic                  alu_valid;
    logic                  mul_valid;
    unit_wb_t              alu_wb;
    unit_wb_t              mul_wb;

    issue_stage #(.IQ_DEPTH(IQ_DEPTH)) u_issue (
        .clk, .rst, .in_valid, .in_instr, .in_credit,
        .id_available, .next_id, .issued,
        .rs1_addr, .rs2_addr, .rs1_reg, .rs2_reg,
        .rs1_pending, .rs2_pending, .rs1_writer, .rs2_writer,
        .rs1_byp_valid, .rs2_byp_valid, .rs1_byp_data, .rs2_byp_data,
        .alu_disp, .mul_disp, .alu_valid, .mul_valid, .claim_rd
    );

    id_tracker u_ids (
        .clk, .rst, .issued, .retired,
        .id_available, .next_id, .oldest_id,
        .empty()
    );

    alu_unit u_alu (
        .clk, .rst, .disp(alu_disp), .valid(alu_valid), .wb(alu_wb)
    );

    mul_unit #(.MUL_LATENCY(MUL_LATENCY)) u_mul (
        .clk, .rst, .disp(mul_disp), .valid(mul_valid), .wb(mul_wb)
    );

    write_back u_wb (
        .clk, .rst, .alu_wb, .mul_wb,
        .issued, .issue_id(next_id), .issue_rd(claim_rd),
        .oldest_id, .retired,
        .rs1_id(rs1_writer), .rs2_id(rs2_writer),
        .rs1_byp_valid, .rs2_byp_valid, .rs1_byp_data, .rs2_byp_data,
        .retire_credit, .retire_valid, .retire_data
    );

    reg_file u_rf (
        .clk, .rst, .rs1_addr, .rs2_addr, .rs1_reg, .rs2_reg,
        .rs1_pending, .rs2_pending, .rs1_writer, .rs2_writer,
        .issued, .issue_id(next_id), .claim_rd,
        .retire_valid, .retire_data
    );

endmodule

`default_nettype wire

//--- bench/retire_core_properties.sv
// Retire core protocol checks
// Credit use on both ports, retire ID order and quiet outputs after reset
`default_nettype none

module retire_core_properties import core_cfg_pkg::*; import instr_types_pkg::*; #(
    parameter int IQ_DEPTH = 4
) (
    input logic     clk,
    input logic     rst,
    input logic     in_valid,
    input logic     in_credit,
    input logic     retire_credit,
    input logic     retire_valid,
    input retire_t  retire_data,
    input logic     alu_valid,
    input logic     mul_valid,
    input unit_wb_t alu_wb,
    input unit_wb_t mul_wb
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [7:0]      in_held;
    logic [7:0]      ret_held;
    logic [ID_W-1:0] next_ret_id;
    int              fail_count = 0;

    ////////////////////////////////////////////////////////////
    // Credits held by the sender and by the core
    // A retire credit is released once its retire_valid is seen
    always_ff @(posedge clk) begin
        if (rst) begin
            in_held     <= 8'(IQ_DEPTH);
            ret_held    <= '0;
            next_ret_id <= '0;
        end else begin
            in_held  <= in_held - 8'(in_valid) + 8'(in_credit);
            ret_held <= ret_held + 8'(retire_credit) - 8'(retire_valid);
            if (retire_valid)
                next_ret_id <= next_ret_id + ID_W'(1);
        end
    end

    ////////////////////////////////////////////////////////////
    // Port and ordering checks
    assert property (@(posedge clk) disable iff (rst) in_valid |-> in_held != '0)
        else begin
            $error("Instruction sent with no input credit held");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (rst) retire_valid |-> ret_held != '0)
        else begin
            $error("Retirement with no retire credit held");
            fail_count++;
        end

    // IDs leave strictly in allocation order
    assert property (@(posedge clk) disable iff (rst)
        retire_valid |-> retire_data.id == next_ret_id)
        else begin
            $error("Retired ID %0d out of order", retire_data.id);
            fail_count++;
        end

    assert property (@(posedge clk) rst |=> !(in_credit || retire_valid || alu_valid
        || mul_valid || alu_wb.done || mul_wb.done))
        else begin
            $error("Control output high in the cycle after reset");
            fail_count++;
        end

endmodule

bind retire_core_top retire_core_properties #(.IQ_DEPTH(IQ_DEPTH)) u_properties (
    .clk(clk),
    .rst(rst),
    .in_valid(in_valid),
    .in_credit(in_credit),
    .retire_credit(retire_credit),
    .retire_valid(retire_valid),
    .retire_data(retire_data),
    .alu_valid(alu_valid),
    .mul_valid(mul_valid),
    .alu_wb(alu_wb),
    .mul_wb(mul_wb)
);

`default_nettype wire

//--- bench/retire_core_tb.sv
// Retire core testbench
// Random programs against an in-order register model, credit-driven
// instruction and retire ports, each retirement checked on arrival
`default_nettype none

module retire_core_tb
    import core_cfg_pkg::*;
    import instr_types_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MUL_LATENCY  = 3;
    localparam int IQ_DEPTH     = 4;
    localparam int NUM_REGS     = 2 ** REG_ADDR_W;
    // Retire slots the consumer offers at once
    localparam int RET_WINDOW   = 4;
    localparam int QUIET_CYCLES = 4 * MUL_LATENCY + 16;
    localparam int TOTAL_INSTR  = 168;
    localparam int CYCLE_LIMIT  = 40 * TOTAL_INSTR;

    logic    clk;
    logic    rst;
    logic    in_valid;
    instr_t  in_instr;
    logic    in_credit;
    logic    retire_credit;
    logic    retire_valid;
    retire_t retire_data;

    integer          seed = 32'h850c_cdbe;
    logic [XLEN-1:0] model_regs [NUM_REGS];
    retire_t         expected_log [$];
    logic            hold_retire;
    string           test_name;
    int              test_num;
    int              sent_count;
    int              credits_back;
    int              ret_granted;
    int              ret_seen;
    int              check_errors;
    int              flow_errors;
    int              errors_at_start;
    int              count_at_start;

    retire_core_top #(.MUL_LATENCY(MUL_LATENCY), .IQ_DEPTH(IQ_DEPTH)) UUT (
        .clk, .rst, .in_valid, .in_instr, .in_credit,
        .retire_credit, .retire_valid, .retire_data
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Reference model
    // Program order with r0 held at zero
    // Writes to r0 still retire
    function automatic void predict(input instr_t ins);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] res;
        retire_t         expected;
        a = model_regs[ins.rs1];
        b = model_regs[ins.rs2];
        case (ins.op)
            OP_ADD:  res = a + b;
            OP_SUB:  res = a - b;
            OP_AND:  res = a & b;
            OP_OR:   res = a | b;
            OP_XOR:  res = a ^ b;
            OP_SLT:  res = ($signed(a) < $signed(b)) ? XLEN'(1) : '0;
            OP_ADDI: res = a + XLEN'($signed(ins.imm));
            OP_MUL:  res = a * b;
            default: res = '0;
        endcase
        if (ins.rd != '0)
            model_regs[ins.rd] = res;
        // IDs rotate from zero after reset
        expected.id   = ID_W'(sent_count);
        expected.rd   = ins.rd;
        expected.data = res;
        expected_log.push_back(expected);
    endfunction

    function automatic instr_t build_instr(input op_t op, input logic [REG_ADDR_W-1:0] rd,
                                           input logic [REG_ADDR_W-1:0] rs1,
                                           input logic [REG_ADDR_W-1:0] rs2,
                                           input logic [IMM_W-1:0] imm);
        instr_t ins;
        ins.op  = op;
        ins.rd  = rd;
        ins.rs1 = rs1;
        ins.rs2 = rs2;
        ins.imm = imm;
        return ins;
    endfunction

    function automatic logic [REG_ADDR_W-1:0] random_reg(input logic nonzero);
        logic [31:0] r;
        r = $random(seed);
        if (nonzero && r[REG_ADDR_W-1:0] == '0)
            return REG_ADDR_W'(1);
        return r[REG_ADDR_W-1:0];
    endfunction

    function automatic logic [IMM_W-1:0] random_imm();
        logic [31:0] r;
        r = $random(seed);
        return r[IMM_W-1:0];
    endfunction

    // MUL folds into ADDI when only the ALU is wanted
    function automatic instr_t random_instr(input logic allow_mul);
        logic [31:0] r;
        instr_t      ins;
        r       = $random(seed);
        ins.op  = op_t'(r[2:0]);
        ins.rd  = r[5:3];
        ins.rs1 = r[8:6];
        ins.rs2 = r[11:9];
        ins.imm = random_imm();
        if (!allow_mul && ins.op == OP_MUL)
            ins.op = OP_ADDI;
        return ins;
    endfunction

    ////////////////////////////////////////////////////////////
    // Port drivers and monitor
    // Called and returns 1 ns after a rising edge
    task automatic send_instr(input instr_t ins);
        while (IQ_DEPTH + credits_back - sent_count <= 0) begin
            @(posedge clk);
            #1;
        end
        in_valid = 1'b1;
        in_instr = ins;
        predict(ins);
        sent_count++;
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    // Consumer with a fixed window of free slots
    initial begin : return_retire_credits
        logic give;
        retire_credit = 1'b0;
        @(posedge clk);
        while (rst)
            @(posedge clk);
        forever begin
            give = !hold_retire && (ret_granted - ret_seen < RET_WINDOW);
            #1;
            retire_credit = give;
            if (give)
                ret_granted++;
            @(posedge clk);
        end
    end

    task automatic check_retirement();
        retire_t expected;
        if (ret_seen >= sent_count) begin
            $display("Retirement of ID %0d arrived with nothing outstanding", retire_data.id);
            check_errors++;
        end else begin
            expected = expected_log[ret_seen];
            assert (retire_data == expected)
            else begin
                $display("Fail %s: expected id %0d rd %0d data %h, actual id %0d rd %0d data %h",
                         test_name, expected.id, expected.rd, expected.data,
                         retire_data.id, retire_data.rd, retire_data.data);
                check_errors++;
            end
        end
        ret_seen++;
    endtask

    // Outputs settle well before the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            if (in_credit)
                credits_back++;
            if (retire_valid)
                check_retirement();
        end
    end

    ////////////////////////////////////////////////////////////
    // Tests
    task automatic start_test(input string name);
        test_num++;
        test_name       = name;
        errors_at_start = check_errors + flow_errors;
        count_at_start  = sent_count;
    endtask

    task automatic finish_test();
        while (ret_seen < sent_count) begin
            @(posedge clk);
            #1;
        end
        $display("Test %0d %s: %0d retired, %0d errors", test_num, test_name,
                 sent_count - count_at_start, check_errors + flow_errors - errors_at_start);
    endtask

    task automatic alu_test();
        start_test("independent ALU ops");
        // Seed r1 to r7 with immediates
        for (int r = 1; r < NUM_REGS; r++)
            send_instr(build_instr(OP_ADDI, REG_ADDR_W'(r), '0, '0, random_imm()));
        for (int i = 0; i < 25; i++)
            send_instr(random_instr(1'b0));
        finish_test();
    endtask

    task automatic mul_chain_test();
        logic [REG_ADDR_W-1:0] prod;
        logic [REG_ADDR_W-1:0] sum;
        start_test("multiplier chains");
        for (int i = 0; i < 8; i++) begin
            prod = random_reg(1'b1);
            sum  = random_reg(1'b1);
            send_instr(build_instr(OP_MUL, prod, random_reg(1'b0), random_reg(1'b0), '0));
            // Product read right away through the bypass
            send_instr(build_instr(OP_ADD, sum, prod, random_reg(1'b0), '0));
            send_instr(build_instr(OP_XOR, random_reg(1'b1), sum, prod, '0));
        end
        finish_test();
    endtask

    task automatic early_done_test();
        start_test("early completion");
        // ADD never reads r1 and finishes ahead of the MUL
        for (int i = 0; i < 8; i++) begin
            send_instr(build_instr(OP_MUL, 3'd1, 3'd2, 3'd3, '0));
            send_instr(build_instr(OP_ADD, 3'd4, 3'd4, 3'd5, '0));
        end
        finish_test();
    endtask

    task automatic backpressure_test();
        int quiet;
        start_test("retire back-pressure");
        hold_retire = 1'b1;
        fork
            begin
                for (int i = 0; i < 20; i++)
                    send_instr(random_instr(1'b1));
            end
            begin
                // Stall shows as a stretch with no credit and no retirement
                quiet = 0;
                while (quiet < QUIET_CYCLES) begin
                    @(negedge clk);
                    if (in_credit || retire_valid)
                        quiet = 0;
                    else
                        quiet++;
                end
                // All IDs taken plus a full issue queue
                assert (sent_count - ret_seen == NUM_IDS + IQ_DEPTH)
                else begin
                    $display("Fail %s: expected %0d in flight, actual %0d", test_name,
                             NUM_IDS + IQ_DEPTH, sent_count - ret_seen);
                    flow_errors++;
                end
                @(posedge clk);
                #1;
                hold_retire = 1'b0;
            end
        join
        finish_test();
    endtask

    task automatic r0_test();
        start_test("writes to r0");
        for (int i = 0; i < 6; i++) begin
            if (i % 2 == 0)
                send_instr(build_instr(OP_ADDI, '0, random_reg(1'b1), '0, random_imm()));
            else
                send_instr(build_instr(OP_MUL, '0, random_reg(1'b1), random_reg(1'b1), '0));
            send_instr(build_instr(OP_ADD, random_reg(1'b1), '0, random_reg(1'b0), '0));
        end
        finish_test();
    endtask

    task automatic random_mix_test();
        start_test("random mix");
        for (int i = 0; i < 64; i++)
            send_instr(random_instr(1'b1));
        finish_test();
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    initial begin
        rst          = 1'b1;
        in_valid     = 1'b0;
        in_instr     = '0;
        hold_retire  = 1'b0;
        model_regs   = '{default: '0};
        test_num     = 0;
        sent_count   = 0;
        credits_back = 0;
        ret_granted  = 0;
        ret_seen     = 0;
        check_errors = 0;
        flow_errors  = 0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        alu_test();
        mul_chain_test();
        early_done_test();
        backpressure_test();
        r0_test();
        random_mix_test();

        $display("Tests %0d, retirements %0d of %0d, check errors %0d, assertion failures %0d",
                 test_num, ret_seen, sent_count, check_errors + flow_errors,
                 UUT.u_properties.fail_count);
        if (check_errors == 0 && flow_errors == 0 && UUT.u_properties.fail_count == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, %0d retirements still missing", cycles,
                 sent_count - ret_seen);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- retire_core.f
hw/core_cfg_pkg.sv
hw/instr_types_pkg.sv
hw/id_tracker.sv
hw/issue_stage.sv
hw/alu_unit.sv
hw/mul_unit.sv
hw/write_back.sv
hw/reg_file.sv
hw/retire_core_top.sv
bench/retire_core_properties.sv
bench/retire_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the retire core testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert \
    --top-module retire_core_tb \
    -f retire_core.f \
    -o retire_core_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Keep running past assertion errors so the testbench can report them
./obj_dir/retire_core_sim +verilator+error+limit+1000 > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
    echo "Simulator exited with status $run_status"
    exit 1
fi

if grep -qx "Simulation passed" "$log"; then
    exit 0
fi
exit 1
